/* rtl/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// processor side address and data
`define CACHE_ADDR_W 32
`define CACHE_WORD_W 64
`define CACHE_STRB_W 8

// line is two words, 16 bytes
`define CACHE_WORDS_PER_LINE 2
`define CACHE_OFFSET_W 4

// 16 sets, tag is what is left of the address
`define CACHE_INDEX_W 4
`define CACHE_TAG_W 24
`define CACHE_WAYS 2

`endif

/* rtl/bank_ram.sv */
`timescale 1ns/1ps

module bank_ram #(
	parameter int width = 64,
	parameter int depth = 16
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     en,
	input  logic                     we,
	input  logic [$clog2(depth)-1:0] addr,
	input  logic [width-1:0]         din,
	output logic [width-1:0]         dout
);

	logic [width-1:0] mem [depth];

	always_ff @(posedge clk) begin
		if (en && we) begin
			mem[addr] <= din;
		end
	end

	// read data shows up one cycle after the enabled read
	always_ff @(posedge clk) begin
		if (rst) begin
			dout <= '0;
		end else if (en && !we) begin
			dout <= mem[addr];
		end
	end

endmodule

/* rtl/cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

	typedef logic [`CACHE_ADDR_W-1:0] addr_t;
	typedef logic [`CACHE_WORD_W-1:0] word_t;
	typedef logic [`CACHE_STRB_W-1:0] strb_t;
	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;
	typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;
	typedef logic [$clog2(`CACHE_WORDS_PER_LINE)-1:0] wsel_t;
	typedef word_t [`CACHE_WORDS_PER_LINE-1:0] cache_line_t;

	localparam int num_sets = 1 << `CACHE_INDEX_W;

	typedef enum logic {
		op_read = 1'b0,
		op_write = 1'b1
	} req_op_e;

	typedef enum logic [1:0] {
		lk_idle,
		lk_lookup,
		lk_wait_miss
	} lookup_state_e;

	typedef enum logic [1:0] {
		mh_idle,
		mh_write_back,
		mh_refill
	} miss_state_e;

	typedef struct packed {
		req_op_e op;
		tag_t tag;
		index_t index;
		offset_t offset;
		strb_t wstrb;
		word_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	typedef struct packed {
		tag_entry_t tag;
		logic dirty;
		cache_line_t line;
	} way_read_t;

	typedef struct packed {
		logic en;
		way_t way;
		index_t index;
		wsel_t word;
		word_t data;
	} word_write_t;

	typedef struct packed {
		logic en;
		way_t way;
		index_t index;
		wsel_t word;
		word_t data;
		tag_entry_t tag;
		logic dirty;
	} fill_write_t;

	// write hit as seen by the store stage, old_data is the word before the write
	typedef struct packed {
		logic en;
		way_t way;
		index_t index;
		wsel_t word;
		strb_t wstrb;
		word_t wdata;
		word_t old_data;
	} hit_write_t;

	typedef struct packed {
		tag_t tag;
		index_t index;
		offset_t offset;
		req_op_e op;
		strb_t wstrb;
		word_t wdata;
		way_t victim_way;
		tag_entry_t victim_tag;
		logic victim_dirty;
		cache_line_t victim_line;
	} miss_info_t;

	typedef struct packed {
		logic valid;
		addr_t addr;
	} mem_rd_req_t;

	typedef struct packed {
		logic dvalid;
		logic dlast;
		word_t data;
	} mem_rd_resp_t;

	typedef struct packed {
		logic valid;
		addr_t addr;
		cache_line_t line;
	} mem_wr_req_t;

	// word within the line, the bits above the byte offset
	function automatic wsel_t word_of(offset_t offset);
		return offset[$clog2(`CACHE_STRB_W) +: $bits(wsel_t)];
	endfunction

	function automatic word_t merge_bytes(word_t old_word, word_t new_word, strb_t strb);
		word_t result;
		result = old_word;
		for (int i = 0; i < `CACHE_STRB_W; i++) begin
			if (strb[i]) begin
				result[i*8 +: 8] = new_word[i*8 +: 8];
			end
		end
		return result;
	endfunction

endpackage

/* rtl/cache_arrays.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_arrays (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  rd_en,
	input  cache_pkg::index_t                     rd_index,
	output cache_pkg::way_read_t [`CACHE_WAYS-1:0] way_rd,
	input  cache_pkg::word_write_t                store_wr,
	input  cache_pkg::fill_write_t                fill_wr
);

	import cache_pkg::*;

	logic [`CACHE_WAYS-1:0][num_sets-1:0] valid_q;
	logic [`CACHE_WAYS-1:0][num_sets-1:0] dirty_q;
	logic [`CACHE_WAYS-1:0] valid_rd;
	logic [`CACHE_WAYS-1:0] dirty_rd;
	tag_entry_t tag_dout [`CACHE_WAYS];
	word_t data_dout [`CACHE_WAYS][`CACHE_WORDS_PER_LINE];

	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
		logic tag_we;
		index_t tag_addr;

		// tag table only changes on refill
		assign tag_we = fill_wr.en && fill_wr.way == way_t'(w);
		assign tag_addr = tag_we ? fill_wr.index : rd_index;

		bank_ram #(.width($bits(tag_entry_t)), .depth(num_sets)) u_tag (
			.clk(clk),
			.rst(rst),
			.en(rd_en || tag_we),
			.we(tag_we),
			.addr(tag_addr),
			.din(fill_wr.tag),
			.dout(tag_dout[w])
		);

		for (genvar b = 0; b < `CACHE_WORDS_PER_LINE; b++) begin : g_bank
			logic bank_store;
			logic bank_fill;
			index_t bank_addr;
			word_t bank_din;

			assign bank_store = store_wr.en && store_wr.way == way_t'(w)
				&& store_wr.word == wsel_t'(b);
			assign bank_fill = fill_wr.en && fill_wr.way == way_t'(w)
				&& fill_wr.word == wsel_t'(b);
			assign bank_addr = bank_store ? store_wr.index : (bank_fill ? fill_wr.index : rd_index);
			assign bank_din = bank_store ? store_wr.data : fill_wr.data;

			bank_ram #(.width(`CACHE_WORD_W), .depth(num_sets)) u_data (
				.clk(clk),
				.rst(rst),
				.en(rd_en || bank_store || bank_fill),
				.we(bank_store || bank_fill),
				.addr(bank_addr),
				.din(bank_din),
				.dout(data_dout[w][b])
			);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (store_wr.en) begin
				dirty_q[store_wr.way][store_wr.index] <= 1'b1;
			end
			if (fill_wr.en) begin
				valid_q[fill_wr.way][fill_wr.index] <= fill_wr.tag.valid;
				dirty_q[fill_wr.way][fill_wr.index] <= fill_wr.dirty;
			end
		end
	end

	// flop bits sampled like the rams so all fields line up
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_rd <= '0;
			dirty_rd <= '0;
		end else if (rd_en) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				valid_rd[w] <= valid_q[w][rd_index];
				dirty_rd[w] <= dirty_q[w][rd_index];
			end
		end
	end

	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			way_rd[w].tag.valid = valid_rd[w] && tag_dout[w].valid;
			way_rd[w].tag.tag = tag_dout[w].tag;
			way_rd[w].dirty = dirty_rd[w];
			for (int b = 0; b < `CACHE_WORDS_PER_LINE; b++) begin
				way_rd[w].line[b] = data_dout[w][b];
			end
		end
	end

endmodule

/* rtl/lookup_stage.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module lookup_stage (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  req_valid,
	input  cache_pkg::cpu_req_t                   req,
	output logic                                  addr_ok,
	output logic                                  data_ok,
	output cache_pkg::word_t                      rdata,
	output logic                                  rd_en,
	output cache_pkg::index_t                     rd_index,
	input  cache_pkg::way_read_t [`CACHE_WAYS-1:0] way_rd,
	input  logic                                  store_busy,
	output cache_pkg::hit_write_t                 hit_wr,
	output logic                                  miss_start,
	output cache_pkg::miss_info_t                 miss_info,
	input  logic                                  fill_done,
	input  cache_pkg::word_t                      fill_word
);

	import cache_pkg::*;

	lookup_state_e state_q;
	cpu_req_t req_q;
	way_t victim_q;
	way_t hit_way;
	way_t victim_way;
	wsel_t wsel;
	word_t hit_word;
	logic [`CACHE_WAYS-1:0] way_hit;
	logic accept;
	logic in_lookup;
	logic any_hit;

	// refill done frees the stage in the same cycle
	assign addr_ok = !store_busy
		&& (state_q == lk_idle || (state_q == lk_wait_miss && fill_done));
	assign accept = req_valid && addr_ok;
	assign rd_en = accept;
	assign rd_index = req.index;

	assign in_lookup = state_q == lk_lookup;
	assign wsel = word_of(req_q.offset);

	always_comb begin
		way_hit = '0;
		hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			way_hit[w] = way_rd[w].tag.valid && way_rd[w].tag.tag == req_q.tag;
			if (way_hit[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	// lowest invalid way wins, else the rotating victim
	always_comb begin
		victim_way = victim_q;
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (!way_rd[w].tag.valid) begin
				victim_way = way_t'(w);
			end
		end
	end

	assign any_hit = |way_hit;
	assign hit_word = way_rd[hit_way].line[wsel];

	// writes complete at lookup whether they hit or not
	assign data_ok = (in_lookup && (any_hit || req_q.op == op_write))
		|| (state_q == lk_wait_miss && fill_done && req_q.op == op_read);
	assign rdata = in_lookup ? hit_word : fill_word;

	always_comb begin
		hit_wr.en = in_lookup && any_hit && req_q.op == op_write;
		hit_wr.way = hit_way;
		hit_wr.index = req_q.index;
		hit_wr.word = wsel;
		hit_wr.wstrb = req_q.wstrb;
		hit_wr.wdata = req_q.wdata;
		hit_wr.old_data = hit_word;
	end

	assign miss_start = in_lookup && !any_hit;

	always_comb begin
		miss_info.tag = req_q.tag;
		miss_info.index = req_q.index;
		miss_info.offset = req_q.offset;
		miss_info.op = req_q.op;
		miss_info.wstrb = req_q.wstrb;
		miss_info.wdata = req_q.wdata;
		miss_info.victim_way = victim_way;
		miss_info.victim_tag = way_rd[victim_way].tag;
		miss_info.victim_dirty = way_rd[victim_way].dirty;
		miss_info.victim_line = way_rd[victim_way].line;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= lk_idle;
			victim_q <= '0;
		end else begin
			case (state_q)
				lk_idle: begin
					if (accept) begin
						state_q <= lk_lookup;
					end
				end
				lk_lookup: begin
					state_q <= any_hit ? lk_idle : lk_wait_miss;
				end
				lk_wait_miss: begin
					if (fill_done) begin
						state_q <= accept ? lk_lookup : lk_idle;
					end
				end
				default: begin
					state_q <= lk_idle;
				end
			endcase
			if (miss_start) begin
				victim_q <= way_t'(victim_q + 1'b1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req;
		end
	end

endmodule

/* rtl/store_stage.sv */
`timescale 1ns/1ps

module store_stage (
	input  logic                   clk,
	input  logic                   rst,
	input  cache_pkg::hit_write_t  hit_wr,
	output logic                   store_busy,
	output cache_pkg::word_write_t store_wr
);

	import cache_pkg::*;

	hit_write_t buf_q;

	// the pulse is held for exactly one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			buf_q.en <= 1'b0;
		end else begin
			buf_q <= hit_wr;
		end
	end

	assign store_busy = buf_q.en;

	always_comb begin
		store_wr.en = buf_q.en;
		store_wr.way = buf_q.way;
		store_wr.index = buf_q.index;
		store_wr.word = buf_q.word;
		// new bytes under the strobes, the rest from the hit word
		store_wr.data = merge_bytes(buf_q.old_data, buf_q.wdata, buf_q.wstrb);
	end

endmodule

/* rtl/miss_handler.sv */
`timescale 1ns/1ps

module miss_handler (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    miss_start,
	input  cache_pkg::miss_info_t   miss_info,
	output cache_pkg::mem_wr_req_t  mem_wr_req,
	input  logic                    mem_wr_ready,
	output cache_pkg::mem_rd_req_t  mem_rd_req,
	input  cache_pkg::mem_rd_resp_t mem_rd_resp,
	output cache_pkg::fill_write_t  fill_wr,
	output logic                    fill_done,
	output cache_pkg::word_t        fill_word
);

	import cache_pkg::*;

	miss_state_e state_q;
	miss_info_t info_q;
	wsel_t beat_q;
	wsel_t req_word;
	strb_t beat_strb;
	word_t beat_data;
	logic beat;

	assign beat = state_q == mh_refill && mem_rd_resp.dvalid;
	assign req_word = word_of(info_q.offset);

	// store data only lands in the requested word of a write miss
	assign beat_strb = (info_q.op == op_write && beat_q == req_word) ? info_q.wstrb : '0;
	assign beat_data = merge_bytes(mem_rd_resp.data, info_q.wdata, beat_strb);

	always_comb begin
		mem_wr_req.valid = state_q == mh_write_back;
		mem_wr_req.addr = {info_q.victim_tag.tag, info_q.index, offset_t'(0)};
		mem_wr_req.line = info_q.victim_line;
	end

	// request drops once the first beat is in
	always_comb begin
		mem_rd_req.valid = state_q == mh_refill && beat_q == '0;
		mem_rd_req.addr = {info_q.tag, info_q.index, offset_t'(0)};
	end

	always_comb begin
		fill_wr.en = beat;
		fill_wr.way = info_q.victim_way;
		fill_wr.index = info_q.index;
		fill_wr.word = beat_q;
		fill_wr.data = beat_data;
		fill_wr.tag.valid = 1'b1;
		fill_wr.tag.tag = info_q.tag;
		fill_wr.dirty = info_q.op == op_write;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= mh_idle;
			beat_q <= '0;
			fill_done <= 1'b0;
		end else begin
			fill_done <= beat && mem_rd_resp.dlast;
			case (state_q)
				mh_idle: begin
					if (miss_start) begin
						beat_q <= '0;
						// clean or empty victims skip the write-back
						if (miss_info.victim_tag.valid && miss_info.victim_dirty) begin
							state_q <= mh_write_back;
						end else begin
							state_q <= mh_refill;
						end
					end
				end
				mh_write_back: begin
					if (mem_wr_ready) begin
						state_q <= mh_refill;
					end
				end
				mh_refill: begin
					if (beat) begin
						beat_q <= wsel_t'(beat_q + 1'b1);
						if (mem_rd_resp.dlast) begin
							state_q <= mh_idle;
						end
					end
				end
				default: begin
					state_q <= mh_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (miss_start) begin
			info_q <= miss_info;
		end
	end

	always_ff @(posedge clk) begin
		if (beat && beat_q == req_word) begin
			fill_word <= beat_data;
		end
	end

endmodule

/* rtl/cache_top.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req_valid,
	input  cache_pkg::cpu_req_t     req,
	output logic                    addr_ok,
	output logic                    data_ok,
	output cache_pkg::word_t        rdata,
	output cache_pkg::mem_rd_req_t  mem_rd_req,
	input  cache_pkg::mem_rd_resp_t mem_rd_resp,
	output cache_pkg::mem_wr_req_t  mem_wr_req,
	input  logic                    mem_wr_ready
);

	import cache_pkg::*;

	logic rd_en;
	index_t rd_index;
	way_read_t [`CACHE_WAYS-1:0] way_rd;
	logic store_busy;
	hit_write_t hit_wr;
	word_write_t store_wr;
	logic miss_start;
	miss_info_t miss_info;
	fill_write_t fill_wr;
	logic fill_done;
	word_t fill_word;

	lookup_stage u_lookup (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req(req),
		.addr_ok(addr_ok),
		.data_ok(data_ok),
		.rdata(rdata),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.way_rd(way_rd),
		.store_busy(store_busy),
		.hit_wr(hit_wr),
		.miss_start(miss_start),
		.miss_info(miss_info),
		.fill_done(fill_done),
		.fill_word(fill_word)
	);

	store_stage u_store (
		.clk(clk),
		.rst(rst),
		.hit_wr(hit_wr),
		.store_busy(store_busy),
		.store_wr(store_wr)
	);

	miss_handler u_miss (
		.clk(clk),
		.rst(rst),
		.miss_start(miss_start),
		.miss_info(miss_info),
		.mem_wr_req(mem_wr_req),
		.mem_wr_ready(mem_wr_ready),
		.mem_rd_req(mem_rd_req),
		.mem_rd_resp(mem_rd_resp),
		.fill_wr(fill_wr),
		.fill_done(fill_done),
		.fill_word(fill_word)
	);

	cache_arrays u_arrays (
		.clk(clk),
		.rst(rst),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.way_rd(way_rd),
		.store_wr(store_wr),
		.fill_wr(fill_wr)
	);

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		rst <= 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* verification/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

	import cache_pkg::*;

	localparam int num_tests = 20;
	localparam int timeout_cycles = num_tests * 40 + 20;

	typedef logic [127:0] val_t;

	// evict holds the expected write-back line address or 0 when none is due
	typedef struct packed {
		req_op_e op;
		logic hit;
		logic [31:0] addr;
		logic [7:0] strb;
		logic [31:0] evict;
		logic [63:0] wdata;
		logic [63:0] expect_rd;
	} test_t;

	logic clk;
	logic rst;
	logic req_valid;
	cpu_req_t req;
	logic addr_ok;
	logic data_ok;
	word_t rdata;
	mem_rd_req_t mem_rd_req;
	mem_rd_resp_t mem_rd_resp = '0;
	mem_wr_req_t mem_wr_req;
	logic mem_wr_ready = 1'b0;

	test_t tests [num_tests];
	string test_name [num_tests];
	int n_tests;
	int errors;
	int failed_tests;
	int cycles = 0;
	logic [31:0] stim_lfsr;
	logic [7:0] shadow [4096];

	// 256 line memory model where written lines shadow the initial contents
	logic [127:0] init_line [256];
	logic [127:0] wr_line [256];
	logic [255:0] written;
	logic [127:0] rd_line;
	logic [31:0] rd_addr;
	logic rd_busy;
	logic rd_beat;
	logic [1:0] rd_wait;
	logic wr_busy;
	logic [1:0] wr_wait;
	logic [31:0] delay_lfsr;
	int rd_reqs;
	int wb_count;
	logic [31:0] wb_addr;
	logic [127:0] wb_data;

	tb_clock u_clock (
		.clk(clk),
		.rst(rst)
	);

	cache_top dut (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req(req),
		.addr_ok(addr_ok),
		.data_ok(data_ok),
		.rdata(rdata),
		.mem_rd_req(mem_rd_req),
		.mem_rd_resp(mem_rd_resp),
		.mem_wr_req(mem_wr_req),
		.mem_wr_ready(mem_wr_ready)
	);

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [63:0] take_bits(int n);
		logic [63:0] bits;
		bits = '0;
		for (int k = 0; k < n; k++) begin
			bits[k] = stim_lfsr[0];
			stim_lfsr = lfsr_next(stim_lfsr);
		end
		return bits;
	endfunction

	function automatic logic [1:0] pick_delay(logic [31:0] s);
		logic [1:0] d;
		d[0] = s[0];
		d[1] = lfsr_next(s) & 32'h1 ? 1'b1 : 1'b0;
		return d;
	endfunction

	function automatic logic [127:0] line_now(logic [7:0] l);
		return written[l] ? wr_line[l] : init_line[l];
	endfunction

	function automatic logic [63:0] shadow_word(logic [31:0] addr);
		logic [63:0] w;
		for (int b = 0; b < 8; b++) begin
			w[b*8 +: 8] = shadow[{addr[11:3], 3'(b)}];
		end
		return w;
	endfunction

	function automatic logic [127:0] shadow_line(logic [31:0] addr);
		logic [127:0] l;
		for (int b = 0; b < 16; b++) begin
			l[b*8 +: 8] = shadow[{addr[11:4], 4'(b)}];
		end
		return l;
	endfunction

	task automatic shadow_write(input logic [31:0] addr, input logic [7:0] strb,
		input logic [63:0] data);
		for (int b = 0; b < 8; b++) begin
			if (strb[b]) begin
				shadow[{addr[11:3], 3'(b)}] = data[b*8 +: 8];
			end
		end
	endtask

	task automatic load_shadow();
		for (int l = 0; l < 256; l++) begin
			for (int b = 0; b < 16; b++) begin
				shadow[{8'(l), 4'(b)}] = init_line[l][b*8 +: 8];
			end
		end
	endtask

	task automatic check_value(input string name, input val_t expected, input val_t actual);
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic add_test(input string name, input req_op_e op, input logic hit,
		input logic [31:0] addr, input logic [7:0] strb, input logic [31:0] evict);
		test_t t;
		t.op = op;
		t.hit = hit;
		t.addr = addr;
		t.strb = strb;
		t.evict = evict;
		t.wdata = (op == op_write) ? take_bits(64) : 64'h0;
		t.expect_rd = '0;
		tests[n_tests] = t;
		test_name[n_tests] = name;
		n_tests++;
	endtask

	// sets 3 and 5 with tags 0 to 3 and hits traced through the victim bit
	task automatic build_table();
		n_tests = 0;
		add_test("rd_miss_a", op_read, 1'b0, 32'h038, 8'h00, 32'h0);
		add_test("rd_hit_a", op_read, 1'b1, 32'h038, 8'h00, 32'h0);
		add_test("wr_hit_a", op_write, 1'b1, 32'h038, 8'h0f, 32'h0);
		add_test("rd_merge_a", op_read, 1'b1, 32'h038, 8'h00, 32'h0);
		add_test("rd_miss_b", op_read, 1'b0, 32'h130, 8'h00, 32'h0);
		add_test("evict_a", op_read, 1'b0, 32'h230, 8'h00, 32'h030);
		add_test("wr_miss_c", op_write, 1'b0, 32'h150, 8'hf0, 32'h0);
		add_test("rd_merge_c", op_read, 1'b1, 32'h150, 8'h00, 32'h0);
		add_test("refetch_a", op_read, 1'b0, 32'h038, 8'h00, 32'h0);
		add_test("wr_hit_c1", op_write, 1'b1, 32'h158, 8'h3c, 32'h0);
		add_test("rd_merge_c1", op_read, 1'b1, 32'h158, 8'h00, 32'h0);
		add_test("reread_b", op_read, 1'b1, 32'h130, 8'h00, 32'h0);
		add_test("reread_c", op_read, 1'b1, 32'h150, 8'h00, 32'h0);
		add_test("reread_a0", op_read, 1'b1, 32'h030, 8'h00, 32'h0);
		add_test("wr_miss_d", op_write, 1'b0, 32'h250, 8'hff, 32'h0);
		add_test("wr_miss_e", op_write, 1'b0, 32'h350, 8'h81, 32'h150);
		add_test("refetch_c", op_read, 1'b0, 32'h150, 8'h00, 32'h250);
		add_test("refetch_d", op_read, 1'b0, 32'h250, 8'h00, 32'h350);
		add_test("reread_a", op_read, 1'b1, 32'h038, 8'h00, 32'h0);
		add_test("refetch_e", op_read, 1'b0, 32'h358, 8'h00, 32'h0);
	endtask

	function automatic cpu_req_t make_req(test_t t);
		cpu_req_t r;
		r.op = t.op;
		r.tag = t.addr[31:8];
		r.index = t.addr[7:4];
		r.offset = t.addr[3:0];
		r.wstrb = t.strb;
		r.wdata = t.wdata;
		return r;
	endfunction

	task automatic run_test(input int i);
		int errors_before;
		int reads_before;
		int wbs_before;
		word_t got;
		errors_before = errors;
		reads_before = rd_reqs;
		wbs_before = wb_count;
		@(posedge clk);
		req_valid <= 1'b1;
		req <= make_req(tests[i]);
		@(negedge clk);
		while (!addr_ok) @(negedge clk);
		// accepted on this edge
		@(posedge clk);
		req_valid <= 1'b0;
		@(negedge clk);
		while (!data_ok) @(negedge clk);
		got = rdata;
		// a write miss is still refilling here
		while (!addr_ok) @(negedge clk);
		if (tests[i].op == op_read) begin
			check_value(test_name[i], val_t'(tests[i].expect_rd), val_t'(got));
		end
		check_value({test_name[i], " mem reads"}, val_t'(tests[i].hit ? 0 : 1),
			val_t'(rd_reqs - reads_before));
		if (!tests[i].hit) begin
			check_value({test_name[i], " rd addr"}, val_t'({tests[i].addr[31:4], 4'h0}),
				val_t'(rd_addr));
		end
		check_value({test_name[i], " write-backs"}, val_t'(tests[i].evict != 0),
			val_t'(wb_count - wbs_before));
		if (tests[i].evict != 0) begin
			check_value({test_name[i], " wb addr"}, val_t'(tests[i].evict), val_t'(wb_addr));
			check_value({test_name[i], " wb line"}, shadow_line(tests[i].evict), wb_data);
		end
		if (tests[i].op == op_write) begin
			shadow_write(tests[i].addr, tests[i].strb, tests[i].wdata);
		end
		if (errors != errors_before) begin
			failed_tests++;
		end
		$display("test %0d %s: %s", i, test_name[i], errors == errors_before ? "ok" : "error");
	endtask

	always @(posedge clk) begin
		mem_rd_resp <= '0;
		if (rst) begin
			rd_busy <= 1'b0;
			rd_beat <= 1'b0;
			rd_wait <= '0;
			wr_busy <= 1'b0;
			wr_wait <= '0;
			mem_wr_ready <= 1'b0;
			written <= '0;
			delay_lfsr <= 32'ha592;
			rd_reqs <= 0;
			wb_count <= 0;
		end else begin
			// two beats in word order after a delay of 0 to 3 cycles
			if (rd_busy) begin
				if (rd_wait != 2'd0) begin
					rd_wait <= rd_wait - 2'd1;
				end else begin
					mem_rd_resp.dvalid <= 1'b1;
					mem_rd_resp.dlast <= rd_beat;
					mem_rd_resp.data <= rd_beat ? rd_line[127:64] : rd_line[63:0];
					rd_beat <= 1'b1;
					if (rd_beat) begin
						rd_busy <= 1'b0;
					end
				end
			end else if (mem_rd_req.valid) begin
				rd_busy <= 1'b1;
				rd_beat <= 1'b0;
				rd_wait <= pick_delay(delay_lfsr);
				delay_lfsr <= lfsr_next(lfsr_next(delay_lfsr));
				rd_line <= line_now(mem_rd_req.addr[11:4]);
				rd_addr <= mem_rd_req.addr;
				rd_reqs <= rd_reqs + 1;
			end
			if (wr_busy) begin
				if (mem_wr_ready) begin
					mem_wr_ready <= 1'b0;
					wr_busy <= 1'b0;
					wr_line[mem_wr_req.addr[11:4]] <= mem_wr_req.line;
					written[mem_wr_req.addr[11:4]] <= 1'b1;
					wb_addr <= mem_wr_req.addr;
					wb_data <= mem_wr_req.line;
					wb_count <= wb_count + 1;
				end else if (wr_wait != 2'd0) begin
					wr_wait <= wr_wait - 2'd1;
				end else begin
					mem_wr_ready <= 1'b1;
				end
			end else if (mem_wr_req.valid) begin
				wr_busy <= 1'b1;
				wr_wait <= pick_delay(delay_lfsr);
				delay_lfsr <= lfsr_next(lfsr_next(delay_lfsr));
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == timeout_cycles) begin
			$display("timeout: the cache did not finish within %0d cycles", timeout_cycles);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		errors = 0;
		failed_tests = 0;
		req_valid <= 1'b0;
		req <= '0;
		stim_lfsr = 32'ha592;
		for (int l = 0; l < 256; l++) begin
			init_line[l][63:0] = take_bits(64);
			init_line[l][127:64] = take_bits(64);
		end
		build_table();
		// expected read values from a pass over the table
		load_shadow();
		for (int i = 0; i < num_tests; i++) begin
			if (tests[i].op == op_write) begin
				shadow_write(tests[i].addr, tests[i].strb, tests[i].wdata);
			end else begin
				tests[i].expect_rd = shadow_word(tests[i].addr);
			end
		end
		load_shadow();
		@(negedge clk);
		while (rst) @(negedge clk);
		check_value("reset addr_ok", val_t'(1'b1), val_t'(addr_ok));
		check_value("reset mem_rd_req", val_t'(1'b0), val_t'(mem_rd_req.valid));
		check_value("reset mem_wr_req", val_t'(1'b0), val_t'(mem_wr_req.valid));
		$display("reset: %s", errors == 0 ? "ok" : "error");
		for (int i = 0; i < num_tests; i++) begin
			run_test(i);
		end
		$display("%0d tests, %0d failed, %0d errors", num_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+rtl
rtl/bank_ram.sv
rtl/cache_pkg.sv
rtl/cache_arrays.sv
rtl/lookup_stage.sv
rtl/store_stage.sv
rtl/miss_handler.sv
rtl/cache_top.sv
verification/tb_clock.sv
verification/cache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cache_tb -f src.f -o cache_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/cache_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
